//--- Makefile
# Verilator build and run of the video fetch testbench

VERILATOR ?= verilator
TOP       ?= video_fetch_tb
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# fails on a nonzero exit or on the fail message in the log
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/fetch_arbiter.sv
// round-robin arbiter draining the bank queues onto the DRAM request port
`timescale 1ns/1ps
`default_nettype none

module fetch_arbiter
	import video_pkg::*;
#(
	parameter int NUM_BANKS = 4
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  fetch_req_t [NUM_BANKS-1:0] q_req,
	input  logic [NUM_BANKS-1:0]        q_valid,
	output logic [NUM_BANKS-1:0]        q_ready,
	output fetch_req_t                  dram_req,
	output logic                        dram_valid,
	input  logic                        dram_ready
);

	localparam int BANK_W = NUM_BANKS > 1 ? $clog2(NUM_BANKS) : 1;

	logic [BANK_W-1:0] ptr;
	logic [BANK_W-1:0] cand;
	logic [BANK_W-1:0] grant;
	logic [BANK_W-1:0] held_bank;
	logic found;
	logic hold;	// request shown but not yet taken

	always_comb begin
		int idx;
		cand = ptr;
		found = 1'b0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			idx = int'(ptr) + i;
			if (idx >= NUM_BANKS)
				idx = idx - NUM_BANKS;
			if (!found && q_valid[idx]) begin
				cand = BANK_W'(idx);
				found = 1'b1;
			end
		end
	end

	assign grant = hold ? held_bank : cand;
	assign dram_valid = hold || found;	// held queue cannot drop its valid
	assign dram_req = q_req[grant];

	always_comb begin
		q_ready = '0;
		q_ready[grant] = dram_ready;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
			hold <= 1'b0;
		end else if (dram_valid && dram_ready) begin
			hold <= 1'b0;
			ptr <= grant == BANK_W'(NUM_BANKS - 1) ? '0 : grant + 1'b1;
		end else begin
			hold <= dram_valid;
		end
	end

	always_ff @(posedge clk)
		held_bank <= grant;

endmodule

`default_nettype wire

//--- logic/fetch_queue.sv
// per-bank fetch request FIFO
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
	import video_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	input  fetch_req_t in_req,
	input  logic       in_valid,
	output logic       in_ready,
	output fetch_req_t out_req,
	output logic       out_valid,
	input  logic       out_ready,
	output logic       empty
);

	localparam int PTR_W = QUEUE_DEPTH > 1 ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	fetch_req_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign in_ready = count != CNT_W'(QUEUE_DEPTH);
	assign out_valid = count != '0;
	assign empty = count == '0;
	assign out_req = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr == PTR_W'(QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr == PTR_W'(QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (push != pop)
				count <= push ? count + 1'b1 : count - 1'b1;
		end
	end

	always_ff @(posedge clk)
		if (push)
			mem[wr_ptr] <= in_req;

endmodule

`default_nettype wire

//--- logic/fetch_scan.sv
// row and column walker issuing one fetch request per column
`timescale 1ns/1ps
`default_nettype none

module fetch_scan
	import video_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic [8:0]  first_row,
	input  logic [8:0]  row_count,
	input  logic [7:0]  vconf,
	input  logic [20:0] video_addr,
	input  logic [3:0]  fetch_sel,
	input  logic [1:0]  fetch_bsl,
	input  logic        scan_ready,
	output logic [7:0]  cnt_col,
	output logic [8:0]  cnt_row,
	output logic        cptr,
	output fetch_req_t  scan_req,
	output logic        scan_valid,
	output logic        busy_scan
);

	logic [8:0] last_row;
	logic [7:0] ncols;
	logic xfer;
	logic col_end;

	assign ncols = line_cols(vmode_e'(vconf[2:0]), vconf[7:6]);
	assign xfer = scan_valid && scan_ready;
	assign col_end = cnt_col == ncols - 8'd1;

	assign scan_valid = busy_scan;
	assign scan_req = '{addr: video_addr, sel: fetch_sel, bsl: fetch_bsl,
		row: cnt_row, col: cnt_col};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_scan <= 1'b0;
			cnt_col <= '0;
			cnt_row <= '0;
			cptr <= 1'b0;
		end else if (!busy_scan) begin
			if (start && row_count != 9'd0) begin	// empty band is ignored
				busy_scan <= 1'b1;
				cnt_col <= '0;
				cnt_row <= first_row;
				cptr <= 1'b0;
			end
		end else if (xfer) begin
			cptr <= ~cptr;	// line widths are even
			if (col_end) begin
				cnt_col <= '0;
				if (cnt_row == last_row)
					busy_scan <= 1'b0;
				else
					cnt_row <= cnt_row + 9'd1;
			end else begin
				cnt_col <= cnt_col + 8'd1;
			end
		end
	end

	always_ff @(posedge clk)
		if (!busy_scan && start)
			last_row <= first_row + row_count - 9'd1;

endmodule

`default_nettype wire

//--- logic/video_fetch_top.sv
// video fetch top: scanner, mode decoder, bank queues and DRAM arbiter
`timescale 1ns/1ps
`default_nettype none

module video_fetch_top
	import video_pkg::*;
#(
	parameter int NUM_BANKS = 4,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  vconf,
	input  logic [7:0]  vpage,
	input  logic [15:0] txt_char,
	input  logic        start,
	input  logic [8:0]  first_row,
	input  logic [8:0]  row_count,
	output logic        busy,
	output mode_par_t   mode_par,
	output fetch_req_t  dram_req,
	output logic        dram_valid,
	input  logic        dram_ready
);

	localparam int BANK_W = NUM_BANKS > 1 ? $clog2(NUM_BANKS) : 1;

	logic [7:0] cnt_col;
	logic [8:0] cnt_row;
	logic cptr;
	logic [20:0] video_addr;
	logic [3:0] fetch_sel;
	logic [1:0] fetch_bsl;
	fetch_req_t scan_req;
	logic scan_valid;
	logic scan_ready;
	logic busy_scan;
	logic scan_start;
	logic [BANK_W-1:0] scan_bank;
	fetch_req_t [NUM_BANKS-1:0] q_req;
	logic [NUM_BANKS-1:0] q_valid;
	logic [NUM_BANKS-1:0] q_ready;
	logic [NUM_BANKS-1:0] q_in_ready;
	logic [NUM_BANKS-1:0] q_empty;

	assign scan_start = start && !busy;	// no restart while draining
	assign busy = busy_scan || !(&q_empty);
	assign scan_bank = BANK_W'(scan_req.addr % NUM_BANKS);
	assign scan_ready = q_in_ready[scan_bank];

	video_mode i_mode (
		.vconf(vconf), .vpage(vpage), .txt_char(txt_char),
		.cnt_col(cnt_col), .cnt_row(cnt_row), .cptr(cptr),
		.video_addr(video_addr), .fetch_sel(fetch_sel), .fetch_bsl(fetch_bsl),
		.mode_par(mode_par)
	);

	fetch_scan i_scan (
		.clk(clk), .rst_n(rst_n), .start(scan_start),
		.first_row(first_row), .row_count(row_count), .vconf(vconf),
		.video_addr(video_addr), .fetch_sel(fetch_sel), .fetch_bsl(fetch_bsl),
		.scan_ready(scan_ready), .cnt_col(cnt_col), .cnt_row(cnt_row), .cptr(cptr),
		.scan_req(scan_req), .scan_valid(scan_valid), .busy_scan(busy_scan)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
			.clk(clk), .rst_n(rst_n),
			.in_req(scan_req), .in_valid(scan_valid && scan_bank == BANK_W'(b)),
			.in_ready(q_in_ready[b]),
			.out_req(q_req[b]), .out_valid(q_valid[b]), .out_ready(q_ready[b]),
			.empty(q_empty[b])
		);
	end

	fetch_arbiter #(.NUM_BANKS(NUM_BANKS)) i_arb (
		.clk(clk), .rst_n(rst_n),
		.q_req(q_req), .q_valid(q_valid), .q_ready(q_ready),
		.dram_req(dram_req), .dram_valid(dram_valid), .dram_ready(dram_ready)
	);

endmodule

`default_nettype wire

//--- logic/video_mode.sv
// video mode decoder: static mode parameters, fetch address and lane selectors
`timescale 1ns/1ps
`default_nettype none

module video_mode
	import video_pkg::*;
(
	input  logic [7:0]  vconf,
	input  logic [7:0]  vpage,
	input  logic [15:0] txt_char,
	input  logic [7:0]  cnt_col,
	input  logic [8:0]  cnt_row,
	input  logic        cptr,
	output logic [20:0] video_addr,
	output logic [3:0]  fetch_sel,
	output logic [1:0]  fetch_bsl,
	output mode_par_t   mode_par
);

	vmode_e vmod;
	logic [1:0] rres;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;
	logic [20:0] addr_zx;
	logic [20:0] addr_16c;
	logic [20:0] addr_256c;
	logic [13:0] addr_tx;

	assign vmod = vmode_e'(vconf[2:0]);
	assign rres = vconf[7:6];

	always_comb begin
		mode_par.hpix_beg = HP_BEG[rres];
		mode_par.hpix_end = HP_END[rres];
		mode_par.vpix_beg = VP_BEG[rres];
		mode_par.vpix_end = VP_END[rres];
		mode_par.hires = (vmod == M_TX) || (vmod == M_T0);	// double pixel rate
		mode_par.go_offs = 5'd18;
		mode_par.video_bw = 4'b1001;	// 1 of 8
		mode_par.render_mode = R_ZX;
		case (vmod)
			M_GS: mode_par.video_bw = 4'b1010;
			M_HC: begin
				mode_par.go_offs = 5'd10;
				mode_par.video_bw = 4'b1010;	// 2 of 8
				mode_par.render_mode = R_HC;
			end
			M_XC: begin
				mode_par.go_offs = 5'd6;
				mode_par.video_bw = 4'b0010;	// 2 of 4
				mode_par.render_mode = R_XC;
			end
			M_TX: begin
				mode_par.go_offs = 5'd10;
				mode_par.video_bw = 4'b1100;	// 4 of 8
				mode_par.render_mode = R_TX;
			end
			M_T0: begin
				mode_par.go_offs = 5'd10;
				mode_par.video_bw = 4'b1010;
			end
			default: ;
		endcase
	end

	// ZX screen layout, even column pixels, odd column attributes
	assign addr_zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};
	assign addr_zx = {vpage, 1'b0, cnt_col[0] ? addr_zx_atr : addr_zx_gfx};

	assign addr_16c = {vpage[7:3], cnt_row, cnt_col[6:0]};
	assign addr_256c = {vpage[7:4], cnt_row, cnt_col};

	always_comb begin
		case (cnt_col[1:0])
			2'd0: addr_tx = {1'b0, cnt_row[8:3], 1'b0, cnt_col[7:2]};	// char codes
			2'd1: addr_tx = {1'b0, cnt_row[8:3], 1'b1, cnt_col[7:2]};	// attributes
			2'd2: addr_tx = {4'b1000, txt_char[7:0], cnt_row[2:1]};	// glyph of char0
			default: addr_tx = {4'b1000, txt_char[15:8], cnt_row[2:1]};
		endcase
	end

	always_comb begin
		case (vmod)
			M_HC: video_addr = addr_16c;
			M_XC: video_addr = addr_256c;
			M_TX: video_addr = {vpage[7:1], addr_tx};
			M_GS: video_addr = '0;
			default: video_addr = addr_zx;
		endcase
	end

	// text selectors run one column ahead of the address cycle
	always_comb begin
		fetch_sel = {~cptr, ~cptr, cptr, cptr};
		fetch_bsl = 2'b10;
		if (vmod == M_TX) begin
			case (cnt_col[1:0])
				2'd1: fetch_sel = 4'b0011;
				2'd2: fetch_sel = 4'b1100;
				2'd3: fetch_sel = 4'b0001;
				default: fetch_sel = 4'b0010;
			endcase
			if (cnt_col[1:0] == 2'd3 || cnt_col[1:0] == 2'd0)
				fetch_bsl = {2{cnt_row[0]}};	// glyph byte follows row parity
		end
	end

endmodule

`default_nettype wire

//--- logic/video_pkg.sv
// video mode and render codes, fetch request and mode parameter structs, line width function
`default_nettype none

package video_pkg;

	typedef enum logic [2:0] {
		M_ZX = 3'd0,	// ZX
		M_HC = 3'd1,	// 16c
		M_XC = 3'd2,	// 256c
		M_TX = 3'd3,	// text
		M_GS = 3'd4,	// giga
		M_T0 = 3'd5,	// ZX hi-res test
		M_T1 = 3'd6,	// reserved
		M_NG = 3'd7	// no graphics
	} vmode_e;

	typedef enum logic [1:0] {
		R_ZX = 2'd0,
		R_HC = 2'd1,
		R_XC = 2'd2,
		R_TX = 2'd3
	} rmode_e;

	typedef struct packed {
		logic [20:0] addr;	// DRAM word address
		logic [3:0]  sel;
		logic [1:0]  bsl;
		logic [8:0]  row;
		logic [7:0]  col;
	} fetch_req_t;

	typedef struct packed {
		logic [8:0] hpix_beg;
		logic [8:0] hpix_end;
		logic [8:0] vpix_beg;
		logic [8:0] vpix_end;
		logic [4:0] go_offs;
		logic [3:0] video_bw;
		rmode_e     render_mode;
		logic       hires;
	} mode_par_t;

	// raster window by resolution index, index 0 is the rightmost entry
	localparam logic [3:0][8:0] HP_BEG = {9'd88, 9'd108, 9'd108, 9'd140};
	localparam logic [3:0][8:0] HP_END = {9'd448, 9'd428, 9'd428, 9'd396};
	localparam logic [3:0][8:0] VP_BEG = {9'd32, 9'd56, 9'd76, 9'd80};
	localparam logic [3:0][8:0] VP_END = {9'd320, 9'd296, 9'd276, 9'd272};

	// fetch columns per raster line
	function automatic logic [7:0] line_cols(input vmode_e mode, input logic [1:0] rres);
		logic [8:0] width;
		logic [7:0] half;
		width = HP_END[rres] - HP_BEG[rres];
		half = width[8:1];
		case (mode)
			M_HC:    line_cols = {1'b0, width[8:2]};
			M_XC:    line_cols = half;
			M_TX:    line_cols = {half[7:2], 2'b00};	// whole char groups only
			default: line_cols = 8'd64;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- tb.f
logic/video_pkg.sv
logic/video_mode.sv
logic/fetch_scan.sv
logic/fetch_queue.sv
logic/fetch_arbiter.sv
logic/video_fetch_top.sv
test/video_fetch_properties.sv
test/video_fetch_tb.sv

//--- test/video_fetch_properties.sv
// DRAM request port assertions for held requests and an idle port in reset
`timescale 1ns/1ps
`default_nettype none

module video_fetch_properties
	import video_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input fetch_req_t dram_req,
	input logic       dram_valid,
	input logic       dram_ready
);

	// a waiting request keeps valid and data until taken
	property req_held;
		@(posedge clk) disable iff (!rst_n)
		dram_valid && !dram_ready |=> dram_valid && $stable(dram_req);
	endproperty

	a_req_held: assert property (req_held)
		else $error("dram request dropped or changed before dram_ready");

	a_reset_idle: assert property (@(posedge clk) !rst_n && $past(!rst_n) |-> !dram_valid)
		else $error("dram_valid high during reset");

endmodule

`default_nettype wire

//--- test/video_fetch_tb.sv
// testbench for video_fetch_top with stimulus, reference model, DRAM port checker and timeout
`timescale 1ns/1ps
`default_nettype none

module video_fetch_tb
	import video_pkg::*;
();

	localparam int NB = 4;
	localparam int NT = 9;
	// vconf of each scan is {rres, 3'b000, mode}
	localparam logic [7:0] T_VCONF [NT] = '{8'h00, 8'h01, 8'hC1, 8'h42, 8'hC2, 8'h03, 8'h80,
		8'hC3, 8'h04};
	localparam logic [7:0] T_VPAGE [NT] = '{8'h05, 8'hA8, 8'h37, 8'h9F, 8'h60, 8'h4E, 8'h12,
		8'hF1, 8'h22};
	localparam logic [8:0] T_FIRST [NT] = '{9'd0, 9'd100, 9'd10, 9'd200, 9'd300, 9'd7, 9'd150,
		9'd33, 9'd0};
	localparam logic [8:0] T_ROWS [NT] = '{9'd4, 9'd2, 9'd2, 9'd2, 9'd1, 9'd3, 9'd3, 9'd2, 9'd1};
	localparam logic T_BP [NT] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
	// raster window per resolution index
	localparam int HB [4] = '{140, 108, 108, 88};
	localparam int HE [4] = '{396, 428, 428, 448};
	localparam int VB [4] = '{80, 76, 56, 32};
	localparam int VE [4] = '{272, 276, 296, 320};
	localparam logic [3:0] TX_SEL [4] = '{4'b0010, 4'b0011, 4'b1100, 4'b0001};

	logic clk;
	logic rst_n;
	logic [7:0] vconf;
	logic [7:0] vpage;
	logic [15:0] txt_char;
	logic start;
	logic [8:0] first_row;
	logic [8:0] row_count;
	logic busy;
	mode_par_t mode_par;
	fetch_req_t dram_req;
	logic dram_valid;
	logic dram_ready;

	logic bp_on;	// random back-pressure on dram_ready
	integer seed = 81020;
	int cycles;
	int limit;
	int received;
	int bank;
	fetch_req_t head;
	fetch_req_t exp_q [NB][$];	// expected requests per bank in scan order

	video_fetch_top #(.NUM_BANKS(NB), .QUEUE_DEPTH(4)) i_dut (
		.clk(clk), .rst_n(rst_n), .vconf(vconf), .vpage(vpage), .txt_char(txt_char),
		.start(start), .first_row(first_row), .row_count(row_count), .busy(busy),
		.mode_par(mode_par), .dram_req(dram_req), .dram_valid(dram_valid),
		.dram_ready(dram_ready)
	);

	// assertions on the DRAM port
	bind fetch_arbiter video_fetch_properties i_props (
		.clk(clk), .rst_n(rst_n), .dram_req(dram_req),
		.dram_valid(dram_valid), .dram_ready(dram_ready)
	);

	always #4 clk = ~clk;

	function automatic int cols_per_line(input logic [7:0] vc);
		int w;
		w = HE[vc[7:6]] - HB[vc[7:6]];
		case (vmode_e'(vc[2:0]))
			M_HC: return w / 4;
			M_XC: return w / 2;
			M_TX: return (w / 2) / 4 * 4;	// whole character groups
			default: return 64;
		endcase
	endfunction

	function automatic mode_par_t exp_par(input logic [7:0] vc);
		mode_par_t p;
		vmode_e m;
		m = vmode_e'(vc[2:0]);
		p.hpix_beg = 9'(HB[vc[7:6]]);
		p.hpix_end = 9'(HE[vc[7:6]]);
		p.vpix_beg = 9'(VB[vc[7:6]]);
		p.vpix_end = 9'(VE[vc[7:6]]);
		p.hires = (m == M_TX) || (m == M_T0);
		p.go_offs = 5'd18;
		p.video_bw = 4'b1001;
		p.render_mode = R_ZX;
		case (m)
			M_GS: p.video_bw = 4'b1010;
			M_HC: begin
				p.go_offs = 5'd10;
				p.video_bw = 4'b1010;
				p.render_mode = R_HC;
			end
			M_XC: begin
				p.go_offs = 5'd6;
				p.video_bw = 4'b0010;
				p.render_mode = R_XC;
			end
			M_TX: begin
				p.go_offs = 5'd10;
				p.video_bw = 4'b1100;
				p.render_mode = R_TX;
			end
			M_T0: begin
				p.go_offs = 5'd10;
				p.video_bw = 4'b1010;
			end
			default: ;
		endcase
		return p;
	endfunction

	function automatic fetch_req_t ref_req(input logic [7:0] vc, input logic [7:0] vp,
		input logic [15:0] tc, input logic [8:0] row, input logic [7:0] col, input logic cp);
		fetch_req_t r;
		logic [13:0] t;
		r.row = row;
		r.col = col;
		r.sel = {~cp, ~cp, cp, cp};
		r.bsl = 2'b10;
		case (vmode_e'(vc[2:0]))
			M_HC: r.addr = {vp[7:3], row, col[6:0]};
			M_XC: r.addr = {vp[7:4], row, col};
			M_GS: r.addr = '0;
			M_TX: begin
				case (col[1:0])
					2'd0: t = {1'b0, row[8:3], 1'b0, col[7:2]};
					2'd1: t = {1'b0, row[8:3], 1'b1, col[7:2]};
					2'd2: t = {4'b1000, tc[7:0], row[2:1]};
					default: t = {4'b1000, tc[15:8], row[2:1]};
				endcase
				r.addr = {vp[7:1], t};
				r.sel = TX_SEL[col[1:0]];
				if (col[1:0] == 2'd0 || col[1:0] == 2'd3)
					r.bsl = {2{row[0]}};
			end
			default: begin	// ZX layout with attributes on odd columns
				if (col[0])
					r.addr = {vp, 1'b0, 3'b110, row[7:3], col[4:1]};
				else
					r.addr = {vp, 1'b0, row[7:6], row[2:0], row[5:3], col[4:1]};
			end
		endcase
		return r;
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0d ns: %s mismatch, got %h expected %h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_mode_table();
		for (int m = 0; m < 8; m++) begin
			for (int r = 0; r < 4; r++) begin
				@(posedge clk);
				#1 vconf = {2'(r), 3'b000, 3'(m)};
				@(negedge clk);
				check(64'(mode_par), 64'(exp_par(vconf)), "mode_par");
			end
		end
	endtask

	task automatic run_scan(input int t);
		int total;
		int cols;
		logic cp;
		fetch_req_t r;
		cols = cols_per_line(T_VCONF[t]);
		total = int'(T_ROWS[t]) * cols;
		@(posedge clk);
		#1;
		vconf = T_VCONF[t];
		vpage = T_VPAGE[t];
		first_row = T_FIRST[t];
		row_count = T_ROWS[t];
		bp_on = T_BP[t];
		received = 0;
		cp = 1'b0;
		for (int i = 0; i < int'(T_ROWS[t]); i++) begin
			for (int c = 0; c < cols; c++) begin
				r = ref_req(T_VCONF[t], T_VPAGE[t], txt_char, T_FIRST[t] + 9'(i), 8'(c), cp);
				exp_q[int'(r.addr % NB)].push_back(r);
				cp = ~cp;
			end
		end
		start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		do @(negedge clk); while (busy);	// end of scan
		check(64'(received), 64'(total), "request count");
		check(64'(dram_valid), 64'd0, "dram_valid after busy");
	endtask

	// transfer is decided by values stable from the falling edge on
	always @(negedge clk) begin
		if (rst_n && dram_valid && dram_ready) begin
			bank = int'(dram_req.addr % NB);
			if (exp_q[bank].size() == 0) begin
				$display("unexpected DRAM request at %0d ns in bank %0d, row %0d column %0d",
					$time, bank, dram_req.row, dram_req.col);
				$display("Result: FAILED");
				$fatal(1);
			end else begin
				head = exp_q[bank].pop_front();
				check(64'(dram_req), 64'(head), "dram request");
				received++;
			end
		end
	end

	always @(posedge clk) begin
		#1;
		if (bp_on)
			dram_ready = ($random(seed) & 3) != 0;
		else
			dram_ready = 1'b1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, the scans did not finish within %0d cycles", limit);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		vconf = '0;
		vpage = '0;
		txt_char = 16'hA53C;
		start = 1'b0;
		first_row = '0;
		row_count = '0;
		dram_ready = 1'b1;
		bp_on = 1'b0;
		cycles = 0;
		received = 0;
		limit = 1000;
		for (int t = 0; t < NT; t++)
			limit += int'(T_ROWS[t]) * cols_per_line(T_VCONF[t]) * 4;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		check_mode_table();
		for (int t = 0; t < NT; t++)
			run_scan(t);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
